// ==== include/gfx_consts.svh ====
// graphics subsystem constants
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// sram banks, pixel i lives in bank i mod NUM_S
`define GFX_NUM_S 4

// bits per colour channel
`define GFX_COLOR_W 4

// horizontal mode, in pixel clocks
`define GFX_H_VISIBLE 32
`define GFX_H_FRONT 2
`define GFX_H_SYNC 4
`define GFX_H_BACK 2

// vertical mode, in lines
`define GFX_V_VISIBLE 16
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 1

`define GFX_SRAM_ADDR_W 18
`define GFX_PIX_IDX_W 9

`endif

// ==== hdl/gfx_pkg.sv ====
// graphics subsystem types
`include "gfx_consts.svh"

package gfx_pkg;

  typedef struct packed {
    logic [`GFX_COLOR_W-1:0] red;
    logic [`GFX_COLOR_W-1:0] grn;
    logic [`GFX_COLOR_W-1:0] blu;
  } pixel_t;

  // wishbone classic, write only, adr is a linear pixel index
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`GFX_PIX_IDX_W-1:0] adr;
    pixel_t                    dat;
  } wb_m2s_t;

  typedef struct packed {logic ack;} wb_s2m_t;

  // one queued framebuffer write, already split by bank
  typedef struct packed {
    logic [$clog2(`GFX_NUM_S)-1:0] bank;
    logic [`GFX_SRAM_ADDR_W-1:0]   addr;
    pixel_t                        pix;
  } fb_write_t;

  typedef struct packed {
    logic [`GFX_SRAM_ADDR_W-1:0] addr;
    pixel_t                      wdata;
    logic                        we_n;
    logic                        oe_n;
  } sram_out_t;

  // element 0 comes from bank 0
  typedef pixel_t [`GFX_NUM_S-1:0] pix_word_t;

endpackage

// ==== hdl/gfx_fifo.sv ====
// synchronous show-ahead fifo
`timescale 1ns/100ps

module gfx_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic pixel_clk,
  input  logic rst_n,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic empty,
  output logic full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem  [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // push on full and pop on empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge pixel_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // head entry is visible before pop
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

endmodule

// ==== hdl/vga_timing.sv ====
// vga sync and position counters
`timescale 1ns/100ps
`include "gfx_consts.svh"

module vga_timing (
  input  logic       pixel_clk,
  input  logic       rst_n,
  output logic       hsync,
  output logic       vsync,
  output logic       visible,
  output logic [5:0] x,
  output logic [4:0] y,
  output logic       frame_start
);
  localparam int H_SYNC_START = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `GFX_H_SYNC;
  localparam int H_TOTAL = H_SYNC_END + `GFX_H_BACK;
  localparam int V_SYNC_START = `GFX_V_VISIBLE + `GFX_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `GFX_V_SYNC;
  localparam int V_TOTAL = V_SYNC_END + `GFX_V_BACK;

  logic [5:0] h_cnt;
  logic [4:0] v_cnt;

  // counters start in the front porch so a vsync comes before any
  // visible pixel and scanout has time to prefetch
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= 5'(`GFX_V_VISIBLE);
    end else if (h_cnt == 6'(H_TOTAL - 1)) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == 5'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // all outputs registered from the same count, so they line up
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hsync       <= 1'b1;
      vsync       <= 1'b1;
      visible     <= 1'b0;
      x           <= '0;
      y           <= '0;
      frame_start <= 1'b0;
    end else begin
      hsync   <= !(h_cnt >= 6'(H_SYNC_START) && h_cnt < 6'(H_SYNC_END));
      vsync   <= !(v_cnt >= 5'(V_SYNC_START) && v_cnt < 5'(V_SYNC_END));
      visible <= (h_cnt < 6'(`GFX_H_VISIBLE)) && (v_cnt < 5'(`GFX_V_VISIBLE));
      x       <= h_cnt;
      y       <= v_cnt;
      // first cycle of the vsync pulse
      frame_start <= (h_cnt == '0) && (v_cnt == 5'(V_SYNC_START));
    end
  end

endmodule

// ==== hdl/gfx_pattern_writer.sv ====
// seeded test pattern writer
`timescale 1ns/100ps
`include "gfx_consts.svh"

module gfx_pattern_writer
  import gfx_pkg::*;
(
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [11:0] seed,
  output wb_m2s_t     wb_m,
  input  wb_s2m_t     wb_s,
  output logic        fill_done
);
  localparam int NUM_PIX = `GFX_H_VISIBLE * `GFX_V_VISIBLE;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STROBE,
    ST_GAP
  } state_t;

  state_t                    state;
  logic [`GFX_PIX_IDX_W-1:0] idx;
  logic [11:0]               seed_q;
  logic [3:0]                px;
  logic [3:0]                py;
  logic [3:0]                pxy;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      idx       <= '0;
      fill_done <= 1'b0;
    end else begin
      case (state)
        // starts while busy are ignored
        ST_IDLE: begin
          if (start) begin
            idx       <= '0;
            fill_done <= 1'b0;
            state     <= ST_STROBE;
          end
        end
        ST_STROBE: begin
          if (wb_s.ack) begin
            if (idx == `GFX_PIX_IDX_W'(NUM_PIX - 1)) begin
              fill_done <= 1'b1;
              state     <= ST_IDLE;
            end else begin
              state <= ST_GAP;
            end
          end
        end
        // stb low for one cycle between writes
        ST_GAP: begin
          idx   <= idx + 1'b1;
          state <= ST_STROBE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (state == ST_IDLE && start) begin
      seed_q <= seed;
    end
  end

  // pattern from position, low four bits only
  assign px  = 4'(idx % `GFX_H_VISIBLE);
  assign py  = 4'(idx / `GFX_H_VISIBLE);
  assign pxy = px + py;

  always_comb begin
    wb_m.cyc     = (state != ST_IDLE);
    wb_m.stb     = (state == ST_STROBE);
    wb_m.we      = (state != ST_IDLE);
    wb_m.adr     = idx;
    wb_m.dat.red = px ^ seed_q[3:0];
    wb_m.dat.grn = py ^ seed_q[7:4];
    wb_m.dat.blu = pxy ^ seed_q[11:8];
  end

endmodule

// ==== hdl/gfx_stripe_mem_ctrl.sv ====
// striped sram bank controller
`timescale 1ns/100ps
`include "gfx_consts.svh"

module gfx_stripe_mem_ctrl
  import gfx_pkg::*;
(
  input  logic                        pixel_clk,
  input  logic                        rst_n,
  input  wb_m2s_t                     wb_m,
  output wb_s2m_t                     wb_s,
  input  logic                        rd_req,
  input  logic [`GFX_SRAM_ADDR_W-1:0] rd_addr,
  output pix_word_t                   rd_data,
  output logic                        rd_valid,
  output sram_out_t                   sram_out   [`GFX_NUM_S],
  input  pixel_t                      sram_rdata [`GFX_NUM_S]
);
  localparam int BANK_W = $clog2(`GFX_NUM_S);

  logic                        ack;
  logic                        q_push;
  logic                        q_pop;
  logic                        q_empty;
  logic                        q_full;
  fb_write_t                   q_din;
  fb_write_t                   q_dout;
  logic [`GFX_SRAM_ADDR_W-1:0] bank_addr  [`GFX_NUM_S];
  pixel_t                      bank_wdata [`GFX_NUM_S];
  logic [`GFX_NUM_S-1:0]       bank_we_n;
  logic [`GFX_NUM_S-1:0]       bank_oe_n;

  // one push per strobe, a full queue holds off the ack
  assign q_push = wb_m.cyc && wb_m.stb && wb_m.we && !ack && !q_full;

  // index i -> bank i mod N, word i / N
  always_comb begin
    q_din.bank = BANK_W'(wb_m.adr % `GFX_NUM_S);
    q_din.addr = `GFX_SRAM_ADDR_W'(wb_m.adr / `GFX_NUM_S);
    q_din.pix  = wb_m.dat;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= q_push;
    end
  end

  assign wb_s.ack = ack;

  gfx_fifo #(
    .T    (fb_write_t),
    .DEPTH(4)
  ) wr_q_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .push     (q_push),
    .din      (q_din),
    .pop      (q_pop),
    .dout     (q_dout),
    .empty    (q_empty),
    .full     (q_full)
  );

  // reads own the banks, writes fill the gaps
  assign q_pop = !rd_req && !q_empty;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      bank_we_n <= '1;
      bank_oe_n <= '1;
      rd_valid  <= 1'b0;
    end else begin
      rd_valid <= rd_req;
      for (int i = 0; i < `GFX_NUM_S; i++) begin
        bank_oe_n[i] <= !rd_req;
        bank_we_n[i] <= !(q_pop && q_dout.bank == BANK_W'(i));
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    for (int i = 0; i < `GFX_NUM_S; i++) begin
      if (rd_req) begin
        bank_addr[i] <= rd_addr;
      end else if (q_pop && q_dout.bank == BANK_W'(i)) begin
        bank_addr[i]  <= q_dout.addr;
        bank_wdata[i] <= q_dout.pix;
      end
    end
  end

  // wide word is sampled by scanout at the end of the oe_n cycle
  always_comb begin
    for (int i = 0; i < `GFX_NUM_S; i++) begin
      sram_out[i].addr  = bank_addr[i];
      sram_out[i].wdata = bank_wdata[i];
      sram_out[i].we_n  = bank_we_n[i];
      sram_out[i].oe_n  = bank_oe_n[i];
      rd_data[i]        = sram_rdata[i];
    end
  end

endmodule

// ==== hdl/gfx_scanout.sv ====
// framebuffer scanout to vga
`timescale 1ns/100ps
`include "gfx_consts.svh"

module gfx_scanout
  import gfx_pkg::*;
(
  input  logic                        pixel_clk,
  input  logic                        rst_n,
  input  logic                        visible,
  input  logic                        hsync_in,
  input  logic                        vsync_in,
  input  logic                        frame_start,
  output logic                        rd_req,
  output logic [`GFX_SRAM_ADDR_W-1:0] rd_addr,
  input  pix_word_t                   rd_data,
  input  logic                        rd_valid,
  output pixel_t                      vga_pixel,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        vga_error
);
  localparam int FRAME_WORDS = `GFX_H_VISIBLE * `GFX_V_VISIBLE / `GFX_NUM_S;
  localparam int FETCH_W = $clog2(FRAME_WORDS + 1);
  localparam int SUB_W = $clog2(`GFX_NUM_S);

  logic [FETCH_W-1:0] fetch_cnt;
  logic [2:0]         occ;
  logic [SUB_W-1:0]   sub;
  logic               want;
  logic               pop;
  logic               fifo_empty;
  pix_word_t          fifo_dout;

  // occ counts words held plus words in flight
  assign want = (occ < 3'd3) && (fetch_cnt < FETCH_W'(FRAME_WORDS)) && !frame_start;
  assign pop  = visible && !fifo_empty && (sub == SUB_W'(`GFX_NUM_S - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rd_req    <= 1'b0;
      // no fetch until the first vsync
      fetch_cnt <= FETCH_W'(FRAME_WORDS);
      occ       <= '0;
      sub       <= '0;
    end else begin
      rd_req <= want;
      occ    <= occ + 3'(want) - 3'(pop);
      if (frame_start) begin
        fetch_cnt <= '0;
        sub       <= '0;
      end else begin
        if (want) begin
          fetch_cnt <= fetch_cnt + 1'b1;
        end
        if (visible && !fifo_empty) begin
          sub <= (sub == SUB_W'(`GFX_NUM_S - 1)) ? '0 : sub + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (want) begin
      rd_addr <= `GFX_SRAM_ADDR_W'(fetch_cnt);
    end
  end

  gfx_fifo #(
    .T    (pix_word_t),
    .DEPTH(4)
  ) pix_q_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .push     (rd_valid),
    .din      (rd_data),
    .pop      (pop),
    .dout     (fifo_dout),
    .empty    (fifo_empty),
    .full     ()
  );

  // one register stage, sync delayed by the same amount as colour
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_pixel <= '0;
      hsync     <= 1'b1;
      vsync     <= 1'b1;
      vga_error <= 1'b0;
    end else begin
      hsync     <= hsync_in;
      vsync     <= vsync_in;
      vga_error <= visible && fifo_empty;
      vga_pixel <= (visible && !fifo_empty) ? fifo_dout[sub] : '0;
    end
  end

endmodule

// ==== hdl/gfx_striped_top.sv ====
// striped framebuffer top
`timescale 1ns/100ps
`include "gfx_consts.svh"

module gfx_striped_top
  import gfx_pkg::*;
(
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [11:0] seed,
  output logic        fill_done,
  output sram_out_t   sram_out   [`GFX_NUM_S],
  input  pixel_t      sram_rdata [`GFX_NUM_S],
  output pixel_t      vga_pixel,
  output logic        hsync,
  output logic        vsync,
  output logic [15:0] error_count
);
  logic                        tim_hsync;
  logic                        tim_vsync;
  logic                        tim_visible;
  logic                        frame_start;
  wb_m2s_t                     wb_m;
  wb_s2m_t                     wb_s;
  logic                        rd_req;
  logic [`GFX_SRAM_ADDR_W-1:0] rd_addr;
  pix_word_t                   rd_data;
  logic                        rd_valid;
  logic                        vga_error;

  vga_timing vga_timing_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .hsync      (tim_hsync),
    .vsync      (tim_vsync),
    .visible    (tim_visible),
    .x          (),
    .y          (),
    .frame_start(frame_start)
  );

  gfx_pattern_writer gfx_pattern_writer_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .start    (start),
    .seed     (seed),
    .wb_m     (wb_m),
    .wb_s     (wb_s),
    .fill_done(fill_done)
  );

  gfx_stripe_mem_ctrl gfx_stripe_mem_ctrl_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .wb_m      (wb_m),
    .wb_s      (wb_s),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .sram_out  (sram_out),
    .sram_rdata(sram_rdata)
  );

  gfx_scanout gfx_scanout_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .visible    (tim_visible),
    .hsync_in   (tim_hsync),
    .vsync_in   (tim_vsync),
    .frame_start(frame_start),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .vga_pixel  (vga_pixel),
    .hsync      (hsync),
    .vsync      (vsync),
    .vga_error  (vga_error)
  );

  // underrun counter
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      error_count <= '0;
    end else if (vga_error) begin
      error_count <= error_count + 1'b1;
    end
  end

endmodule

// ==== testbench/tb_sram_bank.sv ====
// asynchronous sram bank model
`timescale 1ns/100ps
`include "gfx_consts.svh"

module tb_sram_bank
  import gfx_pkg::*;
(
  input  logic      pixel_clk,
  input  sram_out_t ctrl,
  output pixel_t    rdata
);
  localparam int WORDS = 2 ** `GFX_SRAM_ADDR_W;

  pixel_t mem [WORDS];

  // write completes at the end of the we_n low cycle
  always @(posedge pixel_clk) begin
    if (!ctrl.we_n) begin
      mem[ctrl.addr] <= ctrl.wdata;
    end
  end

  // combinational read, floating bus seen as zero
  assign rdata = ctrl.oe_n ? '0 : mem[ctrl.addr];

endmodule

// ==== testbench/tb_gfx_striped_top.sv ====
// striped framebuffer testbench
`timescale 1ns/100ps
`include "gfx_consts.svh"

module tb_gfx_striped_top;
  import gfx_pkg::*;

  localparam int H_VIS = `GFX_H_VISIBLE;
  localparam int V_VIS = `GFX_V_VISIBLE;
  localparam int H_SYNC_START = H_VIS + `GFX_H_FRONT;
  localparam int V_SYNC_START = V_VIS + `GFX_V_FRONT;
  localparam int H_TOTAL = H_SYNC_START + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int V_TOTAL = V_SYNC_START + `GFX_V_SYNC + `GFX_V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int FILL_LIMIT = 4 * H_VIS * V_VIS;

  logic        pixel_clk;
  logic        rst_n;
  logic        start;
  logic [11:0] seed;
  logic        fill_done;
  sram_out_t   sram_out   [`GFX_NUM_S];
  pixel_t      sram_rdata [`GFX_NUM_S];
  pixel_t      vga_pixel;
  logic        hsync;
  logic        vsync;
  logic [15:0] error_count;

  integer      seed_var;
  int          pixel_errs;
  int          sync_errs;
  int          value_errs;
  logic        timed_out;
  logic        frame_req;
  logic [11:0] req_seed;
  logic        frame_active;
  logic [11:0] frame_seed;
  int          frames_done;
  logic        locked;
  logic        vs_q;
  logic        exp_hsync;
  logic        exp_vsync;
  int          hpos;
  int          vpos;
  pixel_t      exp_pix;

  gfx_striped_top dut_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .start      (start),
    .seed       (seed),
    .fill_done  (fill_done),
    .sram_out   (sram_out),
    .sram_rdata (sram_rdata),
    .vga_pixel  (vga_pixel),
    .hsync      (hsync),
    .vsync      (vsync),
    .error_count(error_count)
  );

  for (genvar b = 0; b < `GFX_NUM_S; b++) begin : bank_g
    tb_sram_bank bank_i (
      .pixel_clk(pixel_clk),
      .ctrl     (sram_out[b]),
      .rdata    (sram_rdata[b])
    );
  end

  initial begin
    pixel_clk = 1'b0;
    forever #10 pixel_clk = ~pixel_clk;
  end

  // expected colour of a visible pixel
  function automatic pixel_t pattern_pixel(input int px, input int py, input logic [11:0] s);
    pixel_t p;
    p.red = px[3:0] ^ s[3:0];
    p.grn = py[3:0] ^ s[7:4];
    p.blu = 4'(px + py) ^ s[11:8];
    return p;
  endfunction

  task automatic drive_cycle();
    @(posedge pixel_clk);
    #2;
  endtask

  task automatic expect_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("FAIL %s: expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_reset_state();
    expect_value("hsync", 16'(hsync), 16'h1);
    expect_value("vsync", 16'(vsync), 16'h1);
    expect_value("vga_pixel", 16'(vga_pixel), 16'h0);
    expect_value("fill_done", 16'(fill_done), 16'h0);
    expect_value("error_count", error_count, 16'h0);
    for (int b = 0; b < `GFX_NUM_S; b++) begin
      expect_value($sformatf("sram_out[%0d].we_n", b), 16'(sram_out[b].we_n), 16'h1);
      expect_value($sformatf("sram_out[%0d].oe_n", b), 16'(sram_out[b].oe_n), 16'h1);
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    int   n;
    n = 0;
    prev = vsync;
    drive_cycle();
    while (!(prev && !vsync) && n < 2 * FRAME_CYCLES) begin
      prev = vsync;
      drive_cycle();
      n++;
    end
    if (!(prev && !vsync)) begin
      timed_out = 1'b1;
      $display("timeout, no falling edge on vsync");
    end
  endtask

  // sync low time over two whole frames
  task automatic measure_sync();
    int hs_low;
    int vs_low;
    hs_low = 0;
    vs_low = 0;
    wait_vsync_fall();
    for (int n = 0; n < 2 * FRAME_CYCLES && !timed_out; n++) begin
      hs_low += !hsync;
      vs_low += !vsync;
      drive_cycle();
    end
    expect_value("hsync low cycles", 16'(hs_low), 16'(2 * V_TOTAL * `GFX_H_SYNC));
    expect_value("vsync low cycles", 16'(vs_low), 16'(2 * H_TOTAL * `GFX_V_SYNC));
  endtask

  task automatic pulse_start(input logic [11:0] s);
    seed  = s;
    start = 1'b1;
    drive_cycle();
    start = 1'b0;
    // new seed on the input must not matter once latched
    seed = 12'($random(seed_var));
    expect_value("fill_done", 16'(fill_done), 16'h0);
  endtask

  task automatic wait_fill_done();
    int n;
    n = 0;
    while (!fill_done && n < FILL_LIMIT) begin
      drive_cycle();
      n++;
    end
    if (!fill_done) begin
      timed_out = 1'b1;
      $display("timeout, fill_done never went high");
    end
  endtask

  task automatic check_next_frame(input logic [11:0] s);
    int n;
    int target;
    n = 0;
    target = frames_done + 1;
    req_seed = s;
    frame_req = 1'b1;
    while (frames_done < target && n < 3 * FRAME_CYCLES) begin
      drive_cycle();
      n++;
    end
    if (frames_done < target) begin
      timed_out = 1'b1;
      $display("timeout, no complete frame was shown");
    end
    expect_value("error_count", error_count, 16'h0);
  endtask

  task automatic run_tests();
    logic [11:0] s;
    int          gap;
    check_reset_state();
    rst_n = 1'b1;
    measure_sync();
    if (timed_out) return;
    for (int r = 0; r < 4; r++) begin
      s = 12'($random(seed_var));
      pulse_start(s);
      if (r == 2) begin
        gap = 100 + int'($unsigned($random(seed_var)) % 1000);
        repeat (gap) drive_cycle();
        pulse_start(12'($random(seed_var)));
      end
      wait_fill_done();
      if (timed_out) return;
      check_next_frame(s);
      if (timed_out) return;
    end
  endtask

  // position tracker and frame checker on the vga outputs
  always begin
    @(posedge pixel_clk);
    #1;
    if (!rst_n) begin
      locked = 1'b0;
      vs_q   = 1'b1;
    end else begin
      if (locked) begin
        hpos++;
        if (hpos == H_TOTAL) begin
          hpos = 0;
          vpos = (vpos + 1) % V_TOTAL;
        end
      end
      if (vs_q && !vsync) begin
        if (locked) begin
          assert (hpos == 0 && vpos == V_SYNC_START) else begin
            sync_errs++;
            $display("vsync fell at an unexpected position, x %0d line %0d", hpos, vpos);
          end
        end
        hpos   = 0;
        vpos   = V_SYNC_START;
        locked = 1'b1;
        if (frame_req) begin
          frame_active = 1'b1;
          frame_seed   = req_seed;
          frame_req    = 1'b0;
        end
      end
      if (locked) begin
        exp_hsync = !(hpos >= H_SYNC_START && hpos < H_SYNC_START + `GFX_H_SYNC);
        exp_vsync = !(vpos >= V_SYNC_START && vpos < V_SYNC_START + `GFX_V_SYNC);
        assert (hsync === exp_hsync) else begin
          sync_errs++;
          $display("FAIL hsync at x %0d line %0d: expected %h got %h",
                   hpos, vpos, exp_hsync, hsync);
        end
        assert (vsync === exp_vsync) else begin
          sync_errs++;
          $display("FAIL vsync at x %0d line %0d: expected %h got %h",
                   hpos, vpos, exp_vsync, vsync);
        end
        if (hpos < H_VIS && vpos < V_VIS) begin
          if (frame_active) begin
            exp_pix = pattern_pixel(hpos, vpos, frame_seed);
            assert (vga_pixel === exp_pix) else begin
              pixel_errs++;
              $display("FAIL vga_pixel at x %0d y %0d: expected %h got %h",
                       hpos, vpos, exp_pix, vga_pixel);
            end
            if (hpos == H_VIS - 1 && vpos == V_VIS - 1) begin
              frame_active = 1'b0;
              frames_done++;
            end
          end
        end else begin
          assert (vga_pixel === 12'h000) else begin
            pixel_errs++;
            $display("FAIL vga_pixel in blanking x %0d line %0d: expected 000 got %h",
                     hpos, vpos, vga_pixel);
          end
        end
      end
      vs_q = vsync;
    end
  end

  initial begin
    rst_n        = 1'b0;
    start        = 1'b0;
    seed         = 12'h000;
    seed_var     = 32'h3d21;
    pixel_errs   = 0;
    sync_errs    = 0;
    value_errs   = 0;
    timed_out    = 1'b0;
    frame_req    = 1'b0;
    req_seed     = 12'h000;
    frame_active = 1'b0;
    frame_seed   = 12'h000;
    frames_done  = 0;
    hpos         = 0;
    vpos         = 0;
    repeat (10) drive_cycle();
    run_tests();
    $display("errors: pixel %0d, sync %0d, value %0d, timeout %0d",
             pixel_errs, sync_errs, value_errs, timed_out);
    if (!timed_out && pixel_errs + sync_errs + value_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== gfx_striped_top.f ====
+incdir+include
hdl/gfx_pkg.sv
hdl/gfx_fifo.sv
hdl/vga_timing.sv
hdl/gfx_pattern_writer.sv
hdl/gfx_stripe_mem_ctrl.sv
hdl/gfx_scanout.sv
hdl/gfx_striped_top.sv
testbench/tb_sram_bank.sv
testbench/tb_gfx_striped_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx_striped_top \
  -f gfx_striped_top.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log \
  && { echo "simulation reported failures"; exit 1; } \
  || { echo "simulation clean"; exit 0; }
